// File: tb.f
common/memtest_pkg.sv
hw/mem_test_seq.sv
hw/cmd_fifo.sv
mem_ctrl/mem_ctrl.sv
hw/mem_test_top.sv
test/ext_mem_model.sv
test/tb_mem_test.sv

// File: test/tb_mem_test.sv
`timescale 1ns/1ps

module tb_mem_test;

  localparam int NUM_WORDS  = 16;
  localparam int FIFO_DEPTH = 4;
  localparam int FLASH_WAIT = 3;
  localparam int NUM_RUNS   = 6;  // Clean, four random, one corrupted
  localparam int NUM_BYTES  = (NUM_WORDS + 3) / 4;
  localparam int NO_FAULT   = -1;
  localparam int FAULT_IDX  = 6;
  localparam int TIMEOUT_NS = NUM_RUNS * NUM_WORDS * 3 * (4 + FLASH_WAIT) * 10 * 2;

  logic                  clk;
  logic                  rst;
  logic                  start;
  memtest_pkg::dat_t     seed;
  logic                  done;
  memtest_pkg::err_cnt_t err_cnt;
  memtest_pkg::dat_t     checksum;
  logic [8:0]            leds;
  memtest_pkg::ext_adr_t mem_adr;
  wire [15:0]            mem_dat;  // Shared data bus
  logic                  oe_n;
  logic                  we_n;
  logic [1:0]            bw;
  logic                  sram_ce_n;
  logic                  flash_ce_n;
  memtest_pkg::ext_adr_t corrupt_adr;
  int                    bad_lane;
  int                    word_wr;
  int                    byte_wr;
  integer                rand_seed;
  memtest_pkg::dat_t     run_seed [NUM_RUNS];
  int                    run_fault [NUM_RUNS];
  int                    checked_cnt = 0;  // Handshake back to stimulus
  int                    pass_cnt = 0;
  int                    fail_cnt = 0;

  mem_test_top #(
    .NUM_WORDS  (NUM_WORDS),
    .FIFO_DEPTH (FIFO_DEPTH),
    .FLASH_WAIT (FLASH_WAIT)
  ) uut (
    .clk (clk), .rst (rst), .start_i (start), .seed_i (seed),
    .done_o (done), .err_cnt_o (err_cnt), .checksum_o (checksum), .leds_o (leds),
    .mem_adr_o (mem_adr), .mem_dat_io (mem_dat), .mem_oe_n_o (oe_n), .mem_we_n_o (we_n),
    .mem_bw_o (bw), .sram_ce_n_o (sram_ce_n), .flash_ce_n_o (flash_ce_n)
  );

  ext_mem_model mem_model (
    .adr_i (mem_adr), .dat_io (mem_dat), .oe_n_i (oe_n), .we_n_i (we_n), .bw_i (bw),
    .sram_ce_n_i (sram_ce_n), .flash_ce_n_i (flash_ce_n), .corrupt_adr_i (corrupt_adr),
    .bad_lane_o (bad_lane), .word_wr_o (word_wr), .byte_wr_o (byte_wr)
  );

  // Flash rule, word a holds a*3 xor 5A5A
  function automatic logic [15:0] flash_word(input logic [18:0] a);
    int m;
    m = a * 3;
    return m[15:0] ^ 16'h5A5A;
  endfunction

  // External word address of flash window entry i
  function automatic logic [18:0] window_adr(input int i);
    int b;
    b = memtest_pkg::FLASH_BASE + 2 * i;
    return {1'b0, b[18:1]};
  endfunction

  // Expected {err_cnt, checksum} for one run
  function automatic logic [23:0] ref_results(input logic [15:0] s, input int fault_idx);
    logic [15:0] stored;
    logic [15:0] got;
    logic [15:0] sum;
    int          errs;
    sum  = '0;
    errs = 0;
    for (int i = 0; i < NUM_WORDS; i++)
    begin
      stored = s ^ i[15:0];  // Word phase pattern
      if (i % 4 == 0)
        stored[7:0] = 8'hA5;  // Low lane from byte phase
      got = stored;
      if (i == fault_idx)
        got[0] = ~got[0];
      if (got != stored && errs < 255)
        errs++;
      sum = sum ^ flash_word(window_adr(i));
    end
    return {errs[7:0], sum};
  endfunction

  function automatic string run_name(input int r);
    if (r == 0)
      return "clean_fixed_seed";
    else if (r == NUM_RUNS - 1)
      return "corrupt_read";
    else
      return $sformatf("random_seed_%0d", r);
  endfunction

  task automatic check_value(input string test, input string what, input int exp,
                             input int act, inout bit ok);
    assert (exp == act)
    else
    begin
      $display("ERR %s %s expected 0x%0h actual 0x%0h", test, what, exp, act);
      ok = 1'b0;
    end
  endtask

  task automatic report_test(input string test, input bit ok);
    if (ok)
    begin
      pass_cnt++;
      $display("PASS %s", test);
    end
    else
    begin
      fail_cnt++;
      $display("FAIL %s", test);
    end
  endtask

  // Start pulse with seed and fault address
  task automatic launch_run(input logic [15:0] s, input int fault);
    @(posedge clk);
    seed  <= s;
    start <= 1'b1;
    if (fault == NO_FAULT)
      corrupt_adr <= '1;  // Never on the bus
    else
      corrupt_adr <= memtest_pkg::RAM_BASE[18:1] + fault;
    @(posedge clk);
    start <= 1'b0;
  endtask

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Stimulus
  initial
  begin
    rand_seed   = 32'h619d3c34;
    rst         = 1'b1;
    start       = 1'b0;
    seed        = '0;
    corrupt_adr = '1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    wait (checked_cnt == 1);  // Reset state seen first
    for (int r = 0; r < NUM_RUNS; r++)
    begin
      run_seed[r]  = (r == 0) ? 16'h3C5A : $random(rand_seed);
      run_fault[r] = (r == NUM_RUNS - 1) ? FAULT_IDX : NO_FAULT;
      launch_run(run_seed[r], run_fault[r]);
      wait (checked_cnt == r + 2);
    end
  end

  // Compare
  initial
  begin : compare
    bit          ok;
    logic [23:0] exp;
    logic [15:0] last_flash;
    @(negedge clk);
    while (rst)
      @(negedge clk);
    ok = 1'b1;
    check_value("reset_state", "done_o", 0, done, ok);
    check_value("reset_state", "sram_ce_n_o", 1, sram_ce_n, ok);
    check_value("reset_state", "flash_ce_n_o", 1, flash_ce_n, ok);
    check_value("reset_state", "mem_oe_n_o", 1, oe_n, ok);
    check_value("reset_state", "mem_we_n_o", 1, we_n, ok);
    check_value("reset_state", "err_cnt_o", 0, err_cnt, ok);
    check_value("reset_state", "checksum_o", 0, checksum, ok);
    assert (mem_dat === 16'hzzzz)
    else
    begin
      $display("ERR reset_state data bus expected zzzz actual %h", mem_dat);
      ok = 1'b0;
    end
    report_test("reset_state", ok);
    checked_cnt = 1;
    last_flash  = flash_word(window_adr(NUM_WORDS - 1));  // Final read of every run
    for (int r = 0; r < NUM_RUNS; r++)
    begin
      while (done)
        @(negedge clk);  // Previous run still shown
      while (!done)
        @(negedge clk);
      ok  = 1'b1;
      exp = ref_results(run_seed[r], run_fault[r]);
      check_value(run_name(r), "err_cnt_o", exp[23:16], err_cnt, ok);
      check_value(run_name(r), "checksum_o", exp[15:0], checksum, ok);
      check_value(run_name(r), "leds_o", last_flash[8:0], leds, ok);
      report_test(run_name(r), ok);
      checked_cnt = r + 2;
    end
    ok = 1'b1;
    assert (bad_lane == 0)
    else
    begin
      $display("Byte enables broke the lane rule on %0d write cycles", bad_lane);
      ok = 1'b0;
    end
    check_value("lane_rule", "word writes", NUM_RUNS * NUM_WORDS, word_wr, ok);
    check_value("lane_rule", "byte writes", NUM_RUNS * NUM_BYTES, byte_wr, ok);
    report_test("lane_rule", ok);
    $display("Tests run %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, the DUT never finished all runs", TIMEOUT_NS);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: test/ext_mem_model.sv
`timescale 1ns/1ps

module ext_mem_model (
  input  memtest_pkg::ext_adr_t adr_i,
  inout  memtest_pkg::dat_t     dat_io,
  input  logic                  oe_n_i,
  input  logic                  we_n_i,
  input  logic [1:0]            bw_i,
  input  logic                  sram_ce_n_i,
  input  logic                  flash_ce_n_i,
  input  memtest_pkg::ext_adr_t corrupt_adr_i,  // Read fault address
  output int                    bad_lane_o,     // Write cycles breaking the lane rule
  output int                    word_wr_o,
  output int                    byte_wr_o
);

  memtest_pkg::dat_t sram [65536];  // 64K words
  memtest_pkg::dat_t raw_word;
  memtest_pkg::dat_t rd_word;

  // Flash word at address a is a*3 xor 5A5A
  function automatic memtest_pkg::dat_t flash_data(input memtest_pkg::ext_adr_t a);
    int m;
    m = a * 3;
    return m[15:0] ^ 16'h5A5A;
  endfunction

  assign raw_word = flash_ce_n_i ? sram[adr_i[15:0]] : flash_data(adr_i);
  assign rd_word  = raw_word ^ {15'd0, adr_i == corrupt_adr_i};  // Flip bit 0 on fault
  assign dat_io   = (!oe_n_i && we_n_i && (!sram_ce_n_i || !flash_ce_n_i)) ? rd_word : 'z;

  initial
  begin
    bad_lane_o = 0;
    word_wr_o  = 0;
    byte_wr_o  = 0;
  end

  // Async SRAM latches data on the rising edge of we_n
  always @(posedge we_n_i)
  begin
    if (flash_ce_n_i === 1'b0)
      bad_lane_o <= bad_lane_o + 1;  // Flash is read-only
    else if (sram_ce_n_i === 1'b0)
    begin
      case (bw_i)
        2'b11:
        begin
          sram[adr_i[15:0]] <= dat_io;
          word_wr_o         <= word_wr_o + 1;
        end
        2'b01, 2'b10:
        begin
          if (dat_io[15:8] !== dat_io[7:0])
            bad_lane_o <= bad_lane_o + 1;  // Byte not replicated
          if (bw_i[0])
            sram[adr_i[15:0]][7:0] <= dat_io[7:0];
          else
            sram[adr_i[15:0]][15:8] <= dat_io[15:8];
          byte_wr_o <= byte_wr_o + 1;
        end
        default:
          bad_lane_o <= bad_lane_o + 1;  // No lane or unknown
      endcase
    end
  end

endmodule

// File: hw/mem_test_top.sv
`timescale 1ns/1ps

module mem_test_top #(
  parameter int NUM_WORDS  = 16,
  parameter int FIFO_DEPTH = 4,
  parameter int FLASH_WAIT = 3
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start_i,
  input  memtest_pkg::dat_t     seed_i,
  output logic                  done_o,
  output memtest_pkg::err_cnt_t err_cnt_o,
  output memtest_pkg::dat_t     checksum_o,
  output logic [8:0]            leds_o,
  output memtest_pkg::ext_adr_t mem_adr_o,
  inout  memtest_pkg::dat_t     mem_dat_io,
  output logic                  mem_oe_n_o,
  output logic                  mem_we_n_o,
  output logic [1:0]            mem_bw_o,
  output logic                  sram_ce_n_o,
  output logic                  flash_ce_n_o
);

  logic              push;
  memtest_pkg::cmd_t seq_cmd;  // Sequencer to queue
  logic              full;
  logic              empty;
  logic              pop;
  memtest_pkg::cmd_t head_cmd; // Queue to controller
  logic              ack;
  memtest_pkg::dat_t rd_dat;
  memtest_pkg::dat_t last_rd;

  mem_test_seq #(
    .NUM_WORDS (NUM_WORDS)
  ) seq0 (
    .clk        (clk),
    .rst        (rst),
    .start_i    (start_i),
    .seed_i     (seed_i),
    .full_i     (full),
    .ack_i      (ack),
    .rd_dat_i   (rd_dat),
    .push_o     (push),
    .cmd_o      (seq_cmd),
    .done_o     (done_o),
    .err_cnt_o  (err_cnt_o),
    .checksum_o (checksum_o),
    .last_rd_o  (last_rd)
  );

  cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo0 (
    .clk      (clk),
    .rst      (rst),
    .push_i   (push),
    .wr_dat_i (seq_cmd),
    .pop_i    (pop),
    .rd_dat_o (head_cmd),
    .full_o   (full),
    .empty_o  (empty)
  );

  mem_ctrl #(
    .FLASH_WAIT (FLASH_WAIT)
  ) mem0 (
    .clk          (clk),
    .rst          (rst),
    .cmd_i        (head_cmd),
    .empty_i      (empty),
    .pop_o        (pop),
    .ack_o        (ack),
    .rd_dat_o     (rd_dat),
    .mem_adr_o    (mem_adr_o),
    .mem_dat_io   (mem_dat_io),
    .mem_oe_n_o   (mem_oe_n_o),
    .mem_we_n_o   (mem_we_n_o),
    .mem_bw_o     (mem_bw_o),
    .sram_ce_n_o  (sram_ce_n_o),
    .flash_ce_n_o (flash_ce_n_o)
  );

  assign leds_o = last_rd[8:0];  // Last word read shown on the board LEDs

endmodule

// File: mem_ctrl/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl #(
  parameter int FLASH_WAIT = 3
) (
  input  logic                  clk,
  input  logic                  rst,
  input  memtest_pkg::cmd_t     cmd_i,
  input  logic                  empty_i,
  output logic                  pop_o,
  output logic                  ack_o,
  output memtest_pkg::dat_t     rd_dat_o,
  output memtest_pkg::ext_adr_t mem_adr_o,
  inout  memtest_pkg::dat_t     mem_dat_io,
  output logic                  mem_oe_n_o,
  output logic                  mem_we_n_o,
  output logic [1:0]            mem_bw_o,
  output logic                  sram_ce_n_o,
  output logic                  flash_ce_n_o
);

  localparam int WAIT_W = $clog2(FLASH_WAIT + 2);

  typedef enum logic [1:0] {
    C_IDLE,
    C_SETUP,
    C_WAIT,
    C_FINISH
  } cstate_t;

  cstate_t             state;
  logic [WAIT_W-1:0]   wait_cnt;  // Flash wait cycles done
  memtest_pkg::cmd_t   cmd_q;     // Command under way
  memtest_pkg::adr_t   cur_adr;
  memtest_pkg::dat_t   cur_dat;
  logic                cur_we;
  logic                cur_byte;
  logic                is_flash;
  logic                wr_sram;
  logic                busy;
  memtest_pkg::dat_t   wr_word;
  logic [7:0]          rd_lane;

  // Unpack held command
  assign cur_adr  = cmd_q[memtest_pkg::CMD_ADR_LSB +: memtest_pkg::ADR_W];
  assign cur_dat  = cmd_q[memtest_pkg::CMD_DAT_LSB +: memtest_pkg::DAT_W];
  assign cur_we   = cmd_q[memtest_pkg::CMD_WE_BIT];
  assign cur_byte = cmd_q[memtest_pkg::CMD_BYTE_BIT];

  assign is_flash = (cur_adr[19:18] == memtest_pkg::FLASH_TAG);
  assign wr_sram  = cur_we && !is_flash;  // Flash writes never reach the bus
  assign busy     = (state != C_IDLE);

  assign pop_o = (state == C_IDLE) && !empty_i;

  always_ff @(posedge clk)
  begin
    if (pop_o)
    begin
      cmd_q <= cmd_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= C_IDLE;
      wait_cnt <= '0;
    end
    else
    begin
      case (state)
        C_IDLE:
        begin
          if (pop_o)
            state <= C_SETUP;
        end
        C_SETUP:
        begin
          wait_cnt <= '0;
          if (is_flash && !cur_we && FLASH_WAIT > 0)
            state <= C_WAIT;  // Slow flash access time
          else
            state <= C_FINISH;
        end
        C_WAIT:
        begin
          if (int'(wait_cnt) == FLASH_WAIT - 1)
            state <= C_FINISH;
          else
            wait_cnt <= wait_cnt + 1'b1;
        end
        default:
        begin
          state <= C_IDLE;  // Ack cycle done
        end
      endcase
    end
  end

  // Bus signals follow the registered state
  assign mem_adr_o    = busy ? {1'b0, cur_adr[18:1]} : '0;
  assign sram_ce_n_o  = !(busy && !is_flash);
  assign flash_ce_n_o = !(busy && is_flash);
  assign mem_oe_n_o   = !(busy && !cur_we);
  assign mem_we_n_o   = !((state == C_SETUP) && wr_sram);  // Pulse in first cycle only

  // Byte writes carry the byte on both halves
  assign wr_word = cur_byte ? {2{cur_dat[7:0]}} : cur_dat;

  // Data held through the cycle after we_n rises
  assign mem_dat_io = (busy && wr_sram) ? wr_word : 'z;

  always_comb
  begin
    if (!busy)
      mem_bw_o = 2'b00;
    else if (!cur_byte)
      mem_bw_o = 2'b11;  // Both lanes
    else if (cur_adr[0])
      mem_bw_o = 2'b10;  // Odd address, high lane
    else
      mem_bw_o = 2'b01;
  end

  // Read data sampled by the sequencer at the ack edge
  assign rd_lane  = cur_adr[0] ? mem_dat_io[15:8] : mem_dat_io[7:0];
  assign rd_dat_o = cur_byte ? {8'h00, rd_lane} : mem_dat_io;
  assign ack_o    = (state == C_FINISH);

endmodule

// File: hw/cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              push_i,
  input  memtest_pkg::cmd_t wr_dat_i,
  input  logic              pop_i,
  output memtest_pkg::cmd_t rd_dat_o,
  output logic              full_o,
  output logic              empty_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  memtest_pkg::cmd_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;  // Occupancy
  logic              do_push;
  logic              do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Pointer increment with wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (int'(p) == FIFO_DEPTH - 1) ? '0 : p + 1'b1;
  endfunction

  // Storage
  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= wr_dat_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_next(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_next(rd_ptr);
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  assign rd_dat_o = mem[rd_ptr];  // Head entry, no latency
  assign full_o   = (int'(count) == FIFO_DEPTH);
  assign empty_o  = (count == '0);

endmodule

// File: hw/mem_test_seq.sv
`timescale 1ns/1ps

module mem_test_seq #(
  parameter int NUM_WORDS = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start_i,
  input  memtest_pkg::dat_t     seed_i,
  input  logic                  full_i,
  input  logic                  ack_i,
  input  memtest_pkg::dat_t     rd_dat_i,
  output logic                  push_o,
  output memtest_pkg::cmd_t     cmd_o,
  output logic                  done_o,
  output memtest_pkg::err_cnt_t err_cnt_o,
  output memtest_pkg::dat_t     checksum_o,
  output memtest_pkg::dat_t     last_rd_o
);

  localparam int NUM_BYTES  = (NUM_WORDS + 3) / 4;       // Every fourth word
  localparam int NUM_WRITES = NUM_WORDS + NUM_BYTES;
  localparam int NUM_ACKS   = NUM_WRITES + 2 * NUM_WORDS;  // Writes, read-back, flash
  localparam int IDX_W      = $clog2(NUM_WORDS + 4);
  localparam int ACK_W      = $clog2(NUM_ACKS + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WORD_WR,
    S_BYTE_WR,
    S_READ,
    S_FLASH,
    S_DRAIN,
    S_DONE
  } state_t;

  state_t               state;
  logic [IDX_W-1:0]     idx;      // Issue index within the window
  logic [ACK_W-1:0]     ack_cnt;  // All acks since start
  logic [ACK_W-1:0]     rd_idx;   // Read acks since start
  memtest_pkg::dat_t    seed_q;
  memtest_pkg::adr_t    cmd_adr;
  memtest_pkg::dat_t    cmd_dat;
  logic                 cmd_we;
  logic                 cmd_byte;
  logic                 issuing;
  logic                 last_issue;
  logic                 start_ok;
  memtest_pkg::err_cnt_t err_cnt;
  memtest_pkg::dat_t    checksum;
  memtest_pkg::dat_t    last_rd;

  // Expected RAM contents after both write phases
  function automatic memtest_pkg::dat_t exp_word(input logic [ACK_W-1:0] i,
                                                 input memtest_pkg::dat_t seed);
    memtest_pkg::dat_t w;
    w = memtest_pkg::dat_t'(i) ^ seed;
    if (i[1:0] == 2'b00)
    begin
      w[7:0] = memtest_pkg::BYTE_MARK;  // Byte lane overwritten
    end
    return w;
  endfunction

  assign start_ok = start_i && (state == S_IDLE || state == S_DONE);
  assign issuing  = (state == S_WORD_WR) || (state == S_BYTE_WR) ||
                    (state == S_READ) || (state == S_FLASH);
  assign push_o   = issuing && !full_i;  // Hold command while queue full

  // Byte phase steps by four
  assign last_issue = (state == S_BYTE_WR) ? (int'(idx) + 4 >= NUM_WORDS)
                                           : (int'(idx) == NUM_WORDS - 1);

  // Command fields from phase and index
  always_comb
  begin
    cmd_adr  = memtest_pkg::RAM_BASE + memtest_pkg::adr_t'({idx, 1'b0});
    cmd_dat  = seed_q ^ memtest_pkg::dat_t'(idx);  // Seeded pattern
    cmd_we   = 1'b1;
    cmd_byte = 1'b0;
    case (state)
      S_BYTE_WR:
      begin
        cmd_dat  = {8'h00, memtest_pkg::BYTE_MARK};  // Low lane, even address
        cmd_byte = 1'b1;
      end
      S_READ:
      begin
        cmd_we = 1'b0;
      end
      S_FLASH:
      begin
        cmd_adr = memtest_pkg::FLASH_BASE + memtest_pkg::adr_t'({idx, 1'b0});
        cmd_dat = '0;
        cmd_we  = 1'b0;
      end
      default:
      begin
        cmd_we = 1'b1;
      end
    endcase
  end

  assign cmd_o = {cmd_adr, cmd_dat, cmd_we, cmd_byte};

  // Seed held for the whole run
  always_ff @(posedge clk)
  begin
    if (start_ok)
    begin
      seed_q <= seed_i;
    end
  end

  // Phase sequencing
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= S_IDLE;
      idx   <= '0;
    end
    else
    begin
      case (state)
        S_IDLE, S_DONE:
        begin
          if (start_i)
          begin
            state <= S_WORD_WR;
            idx   <= '0;
          end
        end
        S_WORD_WR, S_BYTE_WR, S_READ, S_FLASH:
        begin
          if (push_o)
          begin
            if (last_issue)
            begin
              idx <= '0;
              case (state)
                S_WORD_WR: state <= S_BYTE_WR;
                S_BYTE_WR: state <= S_READ;
                S_READ:    state <= S_FLASH;
                default:   state <= S_DRAIN;  // Last flash read queued
              endcase
            end
            else
            begin
              idx <= idx + ((state == S_BYTE_WR) ? IDX_W'(4) : IDX_W'(1));
            end
          end
        end
        S_DRAIN:
        begin
          if (int'(ack_cnt) == NUM_ACKS)
          begin
            state <= S_DONE;  // Every ack back
          end
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Ack tracking and result accumulation
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ack_cnt  <= '0;
      rd_idx   <= '0;
      err_cnt  <= '0;
      checksum <= '0;
      last_rd  <= '0;
    end
    else if (start_ok)
    begin
      ack_cnt  <= '0;
      rd_idx   <= '0;
      err_cnt  <= '0;
      checksum <= '0;
    end
    else if (ack_i)
    begin
      ack_cnt <= ack_cnt + 1'b1;
      if (int'(ack_cnt) >= NUM_WRITES)  // Acks return in order so writes come first
      begin
        rd_idx  <= rd_idx + 1'b1;
        last_rd <= rd_dat_i;
        if (int'(rd_idx) < NUM_WORDS)
        begin
          if (rd_dat_i != exp_word(rd_idx, seed_q) && err_cnt != '1)
          begin
            err_cnt <= err_cnt + 1'b1;  // Saturates at 255
          end
        end
        else
        begin
          checksum <= checksum ^ rd_dat_i;  // Flash window
        end
      end
    end
  end

  assign done_o     = (state == S_DONE);
  assign err_cnt_o  = err_cnt;
  assign checksum_o = checksum;
  assign last_rd_o  = last_rd;

endmodule

// File: common/memtest_pkg.sv
package memtest_pkg;

  // Bus widths
  localparam int ADR_W     = 20;  // Byte address
  localparam int DAT_W     = 16;  // SRAM and flash data word
  localparam int EXT_ADR_W = 19;  // Word address on the board bus
  localparam int ERR_W     = 8;

  typedef logic [ADR_W-1:0]     adr_t;
  typedef logic [DAT_W-1:0]     dat_t;
  typedef logic [EXT_ADR_W-1:0] ext_adr_t;
  typedef logic [ERR_W-1:0]     err_cnt_t;

  // Region decode on byte address bits 19 and 18
  localparam logic [1:0] FLASH_TAG = 2'b11;

  // Test windows
  localparam adr_t RAM_BASE   = 20'h00000;
  localparam adr_t FLASH_BASE = 20'hC0000;  // Flash read region

  // Low byte written into every fourth word by the byte phase
  localparam logic [7:0] BYTE_MARK = 8'hA5;

  // Packed command word {adr, dat, we, byte}
  localparam int CMD_BYTE_BIT = 0;
  localparam int CMD_WE_BIT   = 1;
  localparam int CMD_DAT_LSB  = 2;
  localparam int CMD_ADR_LSB  = CMD_DAT_LSB + DAT_W;
  localparam int CMD_W        = ADR_W + DAT_W + 2;  // 38 bits

  typedef logic [CMD_W-1:0] cmd_t;

endpackage
